//--- verilog/noc_arb_pkg.sv
package noc_arb_pkg;

    localparam int NUM_PORTS = 4;               // input ports on this output
    localparam int PORT_W    = 2;               // binary port index
    localparam int AGE_W     = 4;               // wait counter width
    localparam int AGE_MAX   = 15;              // saturation point
    localparam int AGE_KEY_W = AGE_W + 1;       // valid bit on top of inverted age

    localparam int PAYLOAD_W = 32;
    localparam int DEST_W    = 6;
    localparam int TAG_W     = 24;

    // wormhole lock states
    localparam logic ST_UNLOCKED = 1'b0;
    localparam logic ST_LOCKED   = 1'b1;

    // head flit view of the payload word
    typedef struct packed {
        logic [PORT_W-1:0] src;                 // stamped by the output stage
        logic [DEST_W-1:0] dest;
        logic [TAG_W-1:0]  tag;
    } hdr_t;

    // same word read as header or as raw body data
    typedef union packed {
        hdr_t                 hdr;
        logic [PAYLOAD_W-1:0] data;
    } flit_payload_u;

    typedef struct packed {
        logic          head;
        logic          tail;
        flit_payload_u payload;
    } flit_t;

    // one wait counter per input port
    typedef logic [NUM_PORTS-1:0][AGE_W-1:0] age_vec_t;

endpackage

//--- verilog/age_counter.sv
`timescale 1ns/1ns

module age_counter (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic [noc_arb_pkg::NUM_PORTS-1:0] valid_i,
    input  logic [noc_arb_pkg::NUM_PORTS-1:0] accept_i,
    output noc_arb_pkg::age_vec_t             ages_o
);
    import noc_arb_pkg::*;

    age_vec_t ages_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ages_q <= '0;
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (!valid_i[p] || accept_i[p]) begin
                    ages_q[p] <= '0;                        // idle or just served
                end else if (ages_q[p] != AGE_W'(AGE_MAX)) begin
                    ages_q[p] <= ages_q[p] + 1'b1;          // still waiting
                end
            end
        end
    end

    assign ages_o = ages_q;

    a_one_accept: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(accept_i)                                  // only the served port restarts
    ) else $error("more than one port accepted in a cycle: %b", accept_i);

endmodule

//--- verilog/oldest_first_select.sv
`timescale 1ns/1ns

module oldest_first_select (
    input  noc_arb_pkg::age_vec_t             ages_i,
    input  logic [noc_arb_pkg::NUM_PORTS-1:0] valid_i,
    output logic [noc_arb_pkg::NUM_PORTS-1:0] free_grant_o
);
    import noc_arb_pkg::*;

    logic [AGE_KEY_W-1:0] keys [NUM_PORTS];     // smallest key is the oldest port
    logic [NUM_PORTS-2:0] le   [NUM_PORTS];     // row i compares port i to the rest
    logic [NUM_PORTS-1:0] is_min;

    // an invalid port gets the top bit set so it never beats a valid one
    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_key
        assign keys[i] = {~valid_i[i], ~ages_i[i]};
    end

    // triangular minimum search
    // upper half uses <= and the lower half is its strict mirror
    // so only the lowest index survives a tie
    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_row
        for (genvar j = 0; j < NUM_PORTS - 1; j++) begin : g_col
            if (i > j) begin : g_mirror
                assign le[i][j] = !(keys[j] <= keys[i]);        // mirror of row j
            end else begin : g_cmp
                assign le[i][j] = keys[i] <= keys[j+1];
            end
        end
        assign is_min[i] = &le[i];
    end

    assign free_grant_o = is_min & valid_i;     // nothing granted when all idle

    always_comb begin
        a_grant_onehot: assert final ($onehot0(free_grant_o))
            else $error("free grant not one-hot: %b", free_grant_o);
    end

endmodule

//--- verilog/wormhole_lock_fsm.sv
`timescale 1ns/1ns

module wormhole_lock_fsm (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic [noc_arb_pkg::NUM_PORTS-1:0] free_grant_i,
    input  logic [noc_arb_pkg::NUM_PORTS-1:0] accept_i,
    input  logic                              acc_head_i,
    input  logic                              acc_tail_i,
    output logic [noc_arb_pkg::NUM_PORTS-1:0] grant_o,
    output logic [noc_arb_pkg::PORT_W-1:0]    grant_idx_o
);
    import noc_arb_pkg::*;

    logic                 state_q;
    logic                 state_d;
    logic [NUM_PORTS-1:0] lock_port_q;          // one-hot owner of the channel
    logic [NUM_PORTS-1:0] lock_port_d;
    logic                 pkt_start;
    logic                 pkt_end;

    assign pkt_start = (|accept_i) && acc_head_i && !acc_tail_i;  // multi-flit head
    assign pkt_end   = (|(accept_i & lock_port_q)) && acc_tail_i;

    always_comb begin
        state_d     = state_q;
        lock_port_d = lock_port_q;
        case (state_q)
            ST_UNLOCKED: begin
                if (pkt_start) begin
                    state_d     = ST_LOCKED;
                    lock_port_d = accept_i;     // the port that sent the head
                end
            end
            default: begin
                if (pkt_end) begin
                    state_d = ST_UNLOCKED;
                end
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q     <= ST_UNLOCKED;
            lock_port_q <= '0;
        end else begin
            state_q     <= state_d;
            lock_port_q <= lock_port_d;
        end
    end

    // locked port keeps the channel even while it has nothing valid
    assign grant_o = (state_q == ST_LOCKED) ? lock_port_q : free_grant_i;

    always_comb begin
        grant_idx_o = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            grant_idx_o = grant_idx_o | ({PORT_W{grant_o[p]}} & PORT_W'(p));
        end
    end

    a_lock_owner: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (state_q == ST_LOCKED) |-> $onehot(lock_port_q)
    ) else $error("locked owner is not a single port: %b", lock_port_q);

endmodule

//--- verilog/flit_out_stage.sv
`timescale 1ns/1ns

module flit_out_stage (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  noc_arb_pkg::flit_t                in_flits_i [noc_arb_pkg::NUM_PORTS],
    input  logic [noc_arb_pkg::NUM_PORTS-1:0] grant_i,
    input  logic [noc_arb_pkg::PORT_W-1:0]    grant_idx_i,
    input  logic                              load_i,
    output logic                              stage_free_o,
    output noc_arb_pkg::flit_t                out_flit_o,
    output logic                              out_valid_o,
    input  logic                              out_ready_i
);
    import noc_arb_pkg::*;

    flit_t mux_flit;
    flit_t stamp_flit;
    flit_t flit_q;
    logic  valid_q;

    // one-hot and-or mux
    always_comb begin
        mux_flit = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            mux_flit = flit_t'(mux_flit | (in_flits_i[p] & {$bits(flit_t){grant_i[p]}}));
        end
    end

    always_comb begin
        stamp_flit = mux_flit;
        if (mux_flit.head) begin
            stamp_flit.payload.hdr.src = grant_idx_i;   // header view only on heads
        end
    end

    assign stage_free_o = !valid_q || out_ready_i;      // empty or draining now

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (load_i) begin
            valid_q <= 1'b1;                            // refill while draining
        end else if (out_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_i) begin
            flit_q <= stamp_flit;
        end
    end

    assign out_flit_o  = flit_q;
    assign out_valid_o = valid_q;

    a_out_stable: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        valid_q && !out_ready_i |=> valid_q && $stable(flit_q)
    ) else $error("output flit changed under back-pressure");

endmodule

//--- verilog/oldest_first_outport.sv
`timescale 1ns/1ns

module oldest_first_outport (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  noc_arb_pkg::flit_t                in_flit_i [noc_arb_pkg::NUM_PORTS],
    input  logic [noc_arb_pkg::NUM_PORTS-1:0] in_valid_i,
    output logic [noc_arb_pkg::NUM_PORTS-1:0] in_ready_o,
    output noc_arb_pkg::flit_t                out_flit_o,
    output logic                              out_valid_o,
    input  logic                              out_ready_i
);
    import noc_arb_pkg::*;

    age_vec_t             ages;
    logic [NUM_PORTS-1:0] free_grant;
    logic [NUM_PORTS-1:0] grant;
    logic [PORT_W-1:0]    grant_idx;
    logic [NUM_PORTS-1:0] accept;
    logic                 stage_free;
    logic                 stage_load;
    logic                 acc_head;
    logic                 acc_tail;

    assign in_ready_o = in_valid_i & grant & {NUM_PORTS{stage_free}};
    assign accept     = in_valid_i & in_ready_o;
    assign stage_load = |accept;

    // head and tail of whichever flit is taken this cycle
    always_comb begin
        acc_head = 1'b0;
        acc_tail = 1'b0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            acc_head = acc_head | (accept[p] & in_flit_i[p].head);
            acc_tail = acc_tail | (accept[p] & in_flit_i[p].tail);
        end
    end

    age_counter u_age_counter (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .valid_i  (in_valid_i),
        .accept_i (accept),
        .ages_o   (ages)
    );

    oldest_first_select u_oldest_first_select (
        .ages_i       (ages),
        .valid_i      (in_valid_i),
        .free_grant_o (free_grant)
    );

    wormhole_lock_fsm u_wormhole_lock_fsm (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .free_grant_i (free_grant),
        .accept_i     (accept),
        .acc_head_i   (acc_head),
        .acc_tail_i   (acc_tail),
        .grant_o      (grant),
        .grant_idx_o  (grant_idx)
    );

    flit_out_stage u_flit_out_stage (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .in_flits_i   (in_flit_i),
        .grant_i      (grant),
        .grant_idx_i  (grant_idx),
        .load_i       (stage_load),
        .stage_free_o (stage_free),
        .out_flit_o   (out_flit_o),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i)
    );

endmodule

//--- verif/tb_oldest_first_outport.sv
`timescale 1ns/1ns

module tb_oldest_first_outport;
    import noc_arb_pkg::*;

    localparam int MAX_CYCLES = 2000;           // all tests together need a few hundred
    localparam int READY_LOW  = 0;
    localparam int READY_HIGH = 1;
    localparam int READY_RAND = 2;

    logic                 clk;
    logic                 rst_n;
    flit_t                in_flit [NUM_PORTS];
    logic [NUM_PORTS-1:0] in_valid;
    logic [NUM_PORTS-1:0] in_ready;
    flit_t                out_flit;
    logic                 out_valid;
    logic                 out_ready;

    flit_t                src_q [NUM_PORTS][$]; // flits still to offer per port
    flit_t                exp_q [NUM_PORTS][$]; // expected output per source port
    int                   pkt_order [$];        // source of each packet on the output
    int                   xfer_src [$];
    int                   xfer_cyc [$];
    logic [NUM_PORTS-1:0] took       = '0;
    int                   ready_mode = READY_LOW;
    int                   cur_port   = -1;      // open packet on the output
    int                   cycle      = 0;

    oldest_first_outport u_oldest_first_outport (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .in_flit_i   (in_flit),
        .in_valid_i  (in_valid),
        .in_ready_o  (in_ready),
        .out_flit_o  (out_flit),
        .out_valid_o (out_valid),
        .out_ready_i (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle > MAX_CYCLES) begin
            stop_run($sformatf("the run timed out after %0d cycles", MAX_CYCLES));
        end
    end

    // senders hold each flit until it is taken
    always @(posedge clk) begin
        #10;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (took[p]) begin
                void'(src_q[p].pop_front());
            end
            in_valid[p] = (src_q[p].size() > 0);
            if (src_q[p].size() > 0) begin
                in_flit[p] = src_q[p][0];
            end
        end
        case (ready_mode)
            READY_LOW:  out_ready = 1'b0;
            READY_HIGH: out_ready = 1'b1;
            default:    out_ready = 1'($urandom_range(0, 1));
        endcase
    end

    // mid-cycle sampling, all inputs settled
    always @(negedge clk) begin
        took = in_valid & in_ready;
        if (rst_n) begin
            assert ($onehot0(in_ready))
                else stop_run("more than one input port was ready in the same cycle");
            assert ((in_ready & ~in_valid) == '0)
                else stop_run("an input port was ready without a valid flit");
            assert (!(out_valid && !out_ready) || in_ready == '0)
                else stop_run("an input port was ready while the output was stalled");
            if (out_valid && out_ready) begin
                check_output(out_flit);
            end
        end
    end

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic stop_on_mismatch(input string msg);
        stop_run($sformatf("Fail at %0t ns: %s", $time, msg));
    endtask

    task automatic check_output(input flit_t f);
        int    p;
        flit_t want;
        if (f.head) begin
            assert (cur_port < 0) else stop_on_mismatch("head flit inside an open packet");
            p = int'(f.payload.hdr.src);
            pkt_order.push_back(p);
        end else begin
            assert (cur_port >= 0) else stop_on_mismatch("body flit with no open packet");
            p = cur_port;
        end
        assert (exp_q[p].size() > 0)
            else stop_on_mismatch($sformatf("unexpected flit %h from port %0d", f, p));
        want = exp_q[p].pop_front();
        assert (f == want)
            else stop_on_mismatch($sformatf("port %0d sent %h, expected %h", p, f, want));
        xfer_src.push_back(p);
        xfer_cyc.push_back(cycle);
        cur_port = f.tail ? -1 : p;
    endtask

    function automatic flit_t make_flit(input logic head, input logic tail,
                                        input logic [PAYLOAD_W-1:0] data);
        flit_t f;
        f.head         = head;
        f.tail         = tail;
        f.payload.data = data;
        return f;
    endfunction

    task automatic send_flit(input int p, input flit_t f, input flit_t want);
        src_q[p].push_back(f);
        exp_q[p].push_back(want);
    endtask

    task automatic queue_packet(input int p, input int len);
        flit_t f;
        flit_t want;
        for (int i = 0; i < len; i++) begin
            f    = make_flit(i == 0, i == len - 1, $urandom());
            want = f;
            if (f.head) begin
                want.payload.hdr.src = PORT_W'(p);  // output stamps the source
            end
            send_flit(p, f, want);
        end
    endtask

    function automatic bit all_idle();
        bit idle;
        idle = (in_valid == '0) && !out_valid;
        for (int p = 0; p < NUM_PORTS; p++) begin
            idle = idle && (src_q[p].size() == 0) && (exp_q[p].size() == 0);
        end
        return idle;
    endfunction

    task automatic start_test();
        @(negedge clk);
        pkt_order.delete();
        xfer_src.delete();
        xfer_cyc.delete();
    endtask

    task automatic wait_drained();
        @(negedge clk);
        while (!all_idle()) @(negedge clk);
    endtask

    task automatic wait_accept(input int p);
        @(negedge clk);
        while (!(in_valid[p] && in_ready[p])) @(negedge clk);
    endtask

    task automatic check_order(input int n, input int want [4]);
        assert (pkt_order.size() == n)
            else stop_on_mismatch($sformatf("%0d packets, expected %0d", pkt_order.size(), n));
        for (int i = 0; i < n; i++) begin
            assert (pkt_order[i] == want[i])
                else stop_on_mismatch($sformatf("packet %0d came from port %0d, expected %0d",
                                                i, pkt_order[i], want[i]));
        end
    endtask

    task automatic run_single_flit();
        flit_t f;
        flit_t want;
        start_test();
        ready_mode = READY_HIGH;
        f    = make_flit(1'b1, 1'b1, 32'h25C3_0F17);
        want = f;
        want.payload.hdr.src = 2'd3;
        send_flit(3, f, want);
        wait_accept(3);
        @(negedge clk);                         // one cycle after the accept
        assert (out_valid && out_flit == want)
            else stop_on_mismatch($sformatf("single flit out %h valid %b, expected %h",
                                            out_flit, out_valid, want));
        wait_drained();
    endtask

    task automatic run_oldest_first();
        int want [4];
        start_test();
        ready_mode = READY_LOW;
        queue_packet(1, 1);                     // fills the stage
        wait_accept(1);
        queue_packet(2, 1);
        repeat (4) @(negedge clk);
        queue_packet(0, 1);
        repeat (3) @(negedge clk);
        ready_mode = READY_HIGH;
        wait_drained();
        want = '{1, 2, 0, 0};
        check_order(3, want);
    endtask

    task automatic run_tie_order();
        int want [4];
        start_test();
        ready_mode = READY_HIGH;
        for (int p = 0; p < NUM_PORTS; p++) begin
            queue_packet(p, 1);
        end
        wait_drained();
        want = '{0, 1, 2, 3};
        check_order(4, want);
    endtask

    task automatic run_wormhole_lock();
        int want [4];
        start_test();
        ready_mode = READY_LOW;
        queue_packet(0, 1);
        wait_accept(0);
        queue_packet(1, 4);                     // older than port 3 at release
        repeat (3) @(negedge clk);
        queue_packet(3, 1);
        repeat (3) @(negedge clk);
        ready_mode = READY_HIGH;
        wait_drained();
        want = '{0, 1, 3, 0};
        check_order(3, want);
        assert (xfer_src.size() == 6) else stop_on_mismatch("wrong flit count in lock test");
        for (int i = 1; i < 5; i++) begin
            assert (xfer_src[i] == 1)
                else stop_on_mismatch($sformatf("flit %0d came from port %0d", i, xfer_src[i]));
        end
        for (int i = 2; i < 5; i++) begin
            assert (xfer_cyc[i] == xfer_cyc[i-1] + 1)
                else stop_on_mismatch($sformatf("gap before packet flit %0d", i));
        end
    endtask

    task automatic run_random_traffic();
        int total;
        int len;
        total = 0;
        start_test();
        ready_mode = READY_RAND;
        for (int n = 0; n < 6; n++) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                len = $urandom_range(1, 4);
                queue_packet(p, len);
                total = total + len;
            end
        end
        wait_drained();
        assert (xfer_src.size() == total)
            else stop_on_mismatch($sformatf("%0d flits out, %0d sent", xfer_src.size(), total));
        assert (pkt_order.size() == 6 * NUM_PORTS)
            else stop_on_mismatch($sformatf("%0d packets out", pkt_order.size()));
    endtask

    initial begin
        void'($urandom(32'h1b8f));
        rst_n     = 1'b0;
        in_valid  = '0;
        out_ready = 1'b0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            in_flit[p] = '0;
        end
        repeat (10) @(posedge clk);
        #10;
        rst_n = 1'b1;
        run_single_flit();
        run_oldest_first();
        run_tie_order();
        run_wormhole_lock();
        run_random_traffic();
        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- files.f
verilog/noc_arb_pkg.sv
verilog/age_counter.sv
verilog/oldest_first_select.sv
verilog/wormhole_lock_fsm.sv
verilog/flit_out_stage.sv
verilog/oldest_first_outport.sv
verif/tb_oldest_first_outport.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_oldest_first_outport
FILELIST  := files.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TEST PASSED" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
